// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

   localparam int XLEN       = 32;
   localparam int OPCODE_W   = 7;
   localparam int FUNCT3_W   = 3;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [OPCODE_W-1:0]   opcode_t;
   typedef logic [FUNCT3_W-1:0]   funct3_t;

   // Major opcodes of the kept subset
   localparam opcode_t OP_REG    = 7'b0110011;
   localparam opcode_t OP_IMM    = 7'b0010011;
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_JAL    = 7'b1101111;
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;

   localparam funct3_t F3_ADD  = 3'b000;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;
   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;
   localparam funct3_t F3_WORD = 3'b010;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_t;

endpackage

// ==== verilog/core_cfg_pkg.sv ====
package core_cfg_pkg;

   localparam rv_isa_pkg::word_t RESET_PC = 32'h0000_0000;

   // One count per data bit
   localparam int CNT_W = 5;

   typedef logic [CNT_W-1:0] bit_cnt_t;

   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXEC,
      MEM,
      LOAD_WB
   } seq_state_t;

endpackage

// ==== verilog/decode_if.sv ====
`timescale 1ns/10ps

interface decode_if;

   rv_isa_pkg::alu_op_t   alu_op;
   logic                  use_imm;
   logic                  is_branch;
   logic                  branch_ne;
   logic                  is_jal;
   logic                  is_lui;
   logic                  is_load;
   logic                  is_store;
   logic                  rd_write;
   rv_isa_pkg::reg_addr_t rd;
   rv_isa_pkg::reg_addr_t rs1;
   rv_isa_pkg::reg_addr_t rs2;
   logic                  imm_bit;

   modport decoder (
      output alu_op, use_imm, is_branch, branch_ne, is_jal, is_lui,
      output is_load, is_store, rd_write, rd, rs1, rs2, imm_bit
   );

   modport exec (
      input alu_op, use_imm, is_branch, branch_ne, is_jal, is_lui,
      input is_load, is_store, rd_write, rd, rs1, rs2, imm_bit
   );

endinterface

// ==== verilog/insn_decoder.sv ====
`timescale 1ns/10ps

module insn_decoder (
   input  logic              clk,
   input  logic              i_rst,
   input  rv_isa_pkg::word_t i_insn,
   input  logic              i_insn_ack,
   input  logic              i_exec_en,
   decode_if.decoder         dec
);

   rv_isa_pkg::word_t   insn_q;
   rv_isa_pkg::word_t   imm_sr;
   rv_isa_pkg::word_t   imm_fmt;
   rv_isa_pkg::opcode_t opcode;
   rv_isa_pkg::funct3_t funct3;
   rv_isa_pkg::alu_op_t arith_op;
   logic                arith_ok;
   logic                word_acc;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         insn_q <= '0;
      end else if (i_insn_ack) begin
         insn_q <= i_insn;
      end
   end

   // Format is chosen from the word on the bus, so the shifter loads on ack
   always_comb begin
      case (i_insn[6:0])
         rv_isa_pkg::OP_STORE:  imm_fmt = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
         rv_isa_pkg::OP_BRANCH: imm_fmt = {{19{i_insn[31]}}, i_insn[31], i_insn[7],
                                           i_insn[30:25], i_insn[11:8], 1'b0};
         rv_isa_pkg::OP_LUI:    imm_fmt = {i_insn[31:12], 12'h000};
         rv_isa_pkg::OP_JAL:    imm_fmt = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12],
                                           i_insn[20], i_insn[30:21], 1'b0};
         default:               imm_fmt = {{20{i_insn[31]}}, i_insn[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_insn_ack) begin
         imm_sr <= imm_fmt;
      end else if (i_exec_en) begin
         imm_sr <= {1'b0, imm_sr[31:1]};
      end
   end

   assign dec.imm_bit = imm_sr[0];

   assign opcode   = insn_q[6:0];
   assign funct3   = insn_q[14:12];
   assign word_acc = funct3 == rv_isa_pkg::F3_WORD;
   assign dec.rd   = insn_q[11:7];
   assign dec.rs1  = insn_q[19:15];
   assign dec.rs2  = insn_q[24:20];

   // Shifts and compares fall through as no-ops
   always_comb begin
      arith_ok = 1'b1;
      case (funct3)
         rv_isa_pkg::F3_XOR: arith_op = rv_isa_pkg::ALU_XOR;
         rv_isa_pkg::F3_OR:  arith_op = rv_isa_pkg::ALU_OR;
         rv_isa_pkg::F3_AND: arith_op = rv_isa_pkg::ALU_AND;
         rv_isa_pkg::F3_ADD: begin
            if (opcode == rv_isa_pkg::OP_REG && insn_q[30]) begin
               arith_op = rv_isa_pkg::ALU_SUB;
            end else begin
               arith_op = rv_isa_pkg::ALU_ADD;
            end
         end
         default: begin
            arith_op = rv_isa_pkg::ALU_ADD;
            arith_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      dec.alu_op    = rv_isa_pkg::ALU_ADD;
      dec.use_imm   = 1'b0;
      dec.is_branch = 1'b0;
      dec.branch_ne = funct3 == rv_isa_pkg::F3_BNE;
      dec.is_jal    = 1'b0;
      dec.is_lui    = 1'b0;
      dec.is_load   = 1'b0;
      dec.is_store  = 1'b0;
      dec.rd_write  = 1'b0;
      case (opcode)
         rv_isa_pkg::OP_REG: begin
            dec.alu_op   = arith_op;
            dec.rd_write = arith_ok;
         end
         rv_isa_pkg::OP_IMM: begin
            dec.alu_op   = arith_op;
            dec.use_imm  = 1'b1;
            dec.rd_write = arith_ok;
         end
         rv_isa_pkg::OP_LUI: begin
            dec.use_imm  = 1'b1;
            dec.is_lui   = 1'b1;
            dec.rd_write = 1'b1;
         end
         rv_isa_pkg::OP_BRANCH: begin
            dec.is_branch = funct3 == rv_isa_pkg::F3_BEQ || funct3 == rv_isa_pkg::F3_BNE;
         end
         rv_isa_pkg::OP_JAL: begin
            dec.alu_op   = rv_isa_pkg::ALU_PASS_B;
            dec.is_jal   = 1'b1;
            dec.rd_write = 1'b1;
         end
         rv_isa_pkg::OP_LOAD: begin
            dec.use_imm  = 1'b1;
            dec.is_load  = word_acc;
            dec.rd_write = word_acc;
         end
         rv_isa_pkg::OP_STORE: begin
            dec.use_imm  = 1'b1;
            dec.is_store = word_acc;
         end
         default: begin
         end
      endcase
   end

   // No instruction capture while the immediate shifts
   a_imm_quiet: assert property (@(posedge clk) disable iff (i_rst)
      i_insn_ack |-> !i_exec_en);

endmodule

// ==== verilog/core_sequencer.sv ====
`timescale 1ns/10ps

module core_sequencer (
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_ibus_ack,
   input  logic                   i_dbus_ack,
   input  logic                   i_cmp_eq,
   decode_if.exec                 dec,
   output logic                   o_ibus_cyc,
   output logic                   o_dbus_cyc,
   output logic                   o_dbus_we,
   output logic                   o_exec_en,
   output logic                   o_load_en,
   output core_cfg_pkg::bit_cnt_t o_cnt,
   output logic                   o_pc_update
);

   core_cfg_pkg::seq_state_t state_q;
   core_cfg_pkg::bit_cnt_t   cnt_q;
   logic ibus_cyc_q;
   logic dbus_cyc_q;
   logic last_bit;
   logic mem_op;
   logic take;

   assign last_bit = &cnt_q;
   assign mem_op   = dec.is_load | dec.is_store;

   // Equality is complete on the last bit
   assign take = dec.is_jal | (dec.is_branch & (i_cmp_eq ^ dec.branch_ne));

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q    <= core_cfg_pkg::FETCH;
         cnt_q      <= '0;
         ibus_cyc_q <= 1'b0;
         dbus_cyc_q <= 1'b0;
      end else begin
         case (state_q)
            core_cfg_pkg::FETCH: begin
               if (ibus_cyc_q && i_ibus_ack) begin
                  ibus_cyc_q <= 1'b0;
                  state_q    <= core_cfg_pkg::DECODE;
               end else begin
                  ibus_cyc_q <= 1'b1;
               end
            end
            core_cfg_pkg::DECODE: begin
               state_q <= core_cfg_pkg::EXEC;
            end
            core_cfg_pkg::EXEC: begin
               cnt_q <= cnt_q + core_cfg_pkg::bit_cnt_t'(1);
               if (last_bit && mem_op) begin
                  state_q    <= core_cfg_pkg::MEM;
                  dbus_cyc_q <= 1'b1;
               end else if (last_bit) begin
                  state_q    <= core_cfg_pkg::FETCH;
                  ibus_cyc_q <= 1'b1;
               end
            end
            core_cfg_pkg::MEM: begin
               if (i_dbus_ack) begin
                  dbus_cyc_q <= 1'b0;
                  if (dec.is_load) begin
                     state_q <= core_cfg_pkg::LOAD_WB;
                  end else begin
                     state_q    <= core_cfg_pkg::FETCH;
                     ibus_cyc_q <= 1'b1;
                  end
               end
            end
            core_cfg_pkg::LOAD_WB: begin
               cnt_q <= cnt_q + core_cfg_pkg::bit_cnt_t'(1);
               if (last_bit) begin
                  state_q    <= core_cfg_pkg::FETCH;
                  ibus_cyc_q <= 1'b1;
               end
            end
            default: state_q <= core_cfg_pkg::FETCH;
         endcase
      end
   end

   assign o_ibus_cyc  = ibus_cyc_q;
   assign o_dbus_cyc  = dbus_cyc_q;
   assign o_dbus_we   = dec.is_store;
   assign o_exec_en   = state_q == core_cfg_pkg::EXEC;
   assign o_load_en   = state_q == core_cfg_pkg::LOAD_WB;
   assign o_cnt       = cnt_q;
   assign o_pc_update = o_exec_en & last_bit & take;

   a_one_bus: assert property (@(posedge clk) disable iff (i_rst)
      !(ibus_cyc_q && dbus_cyc_q));

   // Each serial pass starts from a count of zero
   a_cnt_pace: assert property (@(posedge clk) disable iff (i_rst)
      !(state_q inside {core_cfg_pkg::EXEC, core_cfg_pkg::LOAD_WB}) |=> cnt_q == '0);

endmodule

// ==== verilog/serial_datapath.sv ====
`timescale 1ns/10ps

module serial_datapath (
   input  logic                   clk,
   input  logic                   i_rst,
   decode_if.exec                 dec,
   input  logic                   i_exec_en,
   input  core_cfg_pkg::bit_cnt_t i_cnt,
   input  logic                   i_pc_update,
   input  logic                   i_rs1_bit,
   input  logic                   i_rs2_bit,
   output logic                   o_rd_bit,
   output rv_isa_pkg::word_t      o_pc,
   output rv_isa_pkg::word_t      o_mem_adr,
   output logic                   o_cmp_eq
);

   rv_isa_pkg::word_t pc_q;
   rv_isa_pkg::word_t adr_q;
   logic [30:0] link_sr;
   logic [30:0] tgt_sr;
   logic first_bit;
   logic last_bit;
   logic sub;
   logic op_a;
   logic op_b;
   logic alu_cin;
   logic alu_sum;
   logic alu_cout;
   logic carry_q;
   logic eq_q;
   logic pc_bit;
   logic link_bit;
   logic link_cout;
   logic link_c_q;
   logic tgt_bit;
   logic tgt_cout;
   logic tgt_c_q;

   function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
      return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
   endfunction

   assign first_bit = i_cnt == '0;
   assign last_bit  = &i_cnt;
   assign sub       = dec.alu_op == rv_isa_pkg::ALU_SUB;

   // LUI has immediate bits in the rs1 field
   assign op_a = dec.is_lui ? 1'b0 : i_rs1_bit;
   assign op_b = dec.is_jal ? link_bit : (dec.use_imm ? dec.imm_bit : i_rs2_bit);

   assign alu_cin             = first_bit ? sub : carry_q;
   assign {alu_cout, alu_sum} = full_add(op_a, op_b ^ sub, alu_cin);

   always_comb begin
      case (dec.alu_op)
         rv_isa_pkg::ALU_AND:    o_rd_bit = op_a & op_b;
         rv_isa_pkg::ALU_OR:     o_rd_bit = op_a | op_b;
         rv_isa_pkg::ALU_XOR:    o_rd_bit = op_a ^ op_b;
         rv_isa_pkg::ALU_PASS_B: o_rd_bit = op_b;
         default:                o_rd_bit = alu_sum;
      endcase
   end

   assign o_cmp_eq = (first_bit | eq_q) & (i_rs1_bit ~^ i_rs2_bit);

   // PC+4 and PC+imm run side by side, the branch picks one at the end
   assign pc_bit                = pc_q[i_cnt];
   assign {link_cout, link_bit} = full_add(pc_bit, i_cnt == core_cfg_pkg::bit_cnt_t'(2),
                                           !first_bit & link_c_q);
   assign {tgt_cout, tgt_bit}   = full_add(pc_bit, dec.imm_bit, !first_bit & tgt_c_q);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc_q     <= core_cfg_pkg::RESET_PC;
         carry_q  <= 1'b0;
         eq_q     <= 1'b0;
         link_c_q <= 1'b0;
         tgt_c_q  <= 1'b0;
      end else if (i_exec_en) begin
         carry_q  <= alu_cout;
         eq_q     <= o_cmp_eq;
         link_c_q <= link_cout;
         tgt_c_q  <= tgt_cout;
         if (last_bit) begin
            pc_q <= i_pc_update ? {tgt_bit, tgt_sr} : {link_bit, link_sr};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_exec_en) begin
         link_sr <= {link_bit, link_sr[30:1]};
         tgt_sr  <= {tgt_bit, tgt_sr[30:1]};
         if (dec.is_load || dec.is_store) begin
            adr_q <= {alu_sum, adr_q[31:1]};
         end
      end
   end

   assign o_pc      = pc_q;
   assign o_mem_adr = adr_q;

endmodule

// ==== verilog/serial_regfile.sv ====
`timescale 1ns/10ps

module serial_regfile (
   input  logic                   clk,
   input  core_cfg_pkg::bit_cnt_t i_cnt,
   input  rv_isa_pkg::reg_addr_t  i_rs1,
   input  rv_isa_pkg::reg_addr_t  i_rs2,
   input  rv_isa_pkg::reg_addr_t  i_rd,
   input  logic                   i_wen,
   input  logic                   i_wbit,
   output logic                   o_rs1_bit,
   output logic                   o_rs2_bit
);

   // One bit per entry, addressed by register and bit position
   logic mem [0:(1 << (rv_isa_pkg::REG_ADDR_W + core_cfg_pkg::CNT_W)) - 1];

   always_ff @(posedge clk) begin
      if (i_wen && i_rd != '0) begin
         mem[{i_rd, i_cnt}] <= i_wbit;
      end
   end

   // x0 is hardwired to zero
   assign o_rs1_bit = (i_rs1 != '0) & mem[{i_rs1, i_cnt}];
   assign o_rs2_bit = (i_rs2 != '0) & mem[{i_rs2, i_cnt}];

endmodule

// ==== verilog/load_store_unit.sv ====
`timescale 1ns/10ps

module load_store_unit (
   input  logic              clk,
   input  logic              i_exec_en,
   input  logic              i_load_en,
   input  logic              i_store,
   input  logic              i_rs2_bit,
   input  rv_isa_pkg::word_t i_dbus_rdt,
   input  logic              i_dbus_ack,
   output rv_isa_pkg::word_t o_dbus_dat,
   output logic              o_load_bit
);

   // Shared by store gathering and load write-back
   rv_isa_pkg::word_t data_q;

   always_ff @(posedge clk) begin
      if (i_exec_en && i_store) begin
         data_q <= {i_rs2_bit, data_q[31:1]};
      end else if (i_dbus_ack && !i_store) begin
         data_q <= i_dbus_rdt;
      end else if (i_load_en) begin
         data_q <= {1'b0, data_q[31:1]};
      end
   end

   assign o_dbus_dat = data_q;
   assign o_load_bit = data_q[0];

endmodule

// ==== verilog/bit_serial_core.sv ====
`timescale 1ns/10ps

module bit_serial_core (
   input  logic              clk,
   input  logic              i_rst,
   output rv_isa_pkg::word_t o_ibus_adr,
   output logic              o_ibus_cyc,
   input  rv_isa_pkg::word_t i_ibus_rdt,
   input  logic              i_ibus_ack,
   output rv_isa_pkg::word_t o_dbus_adr,
   output rv_isa_pkg::word_t o_dbus_dat,
   output logic              o_dbus_we,
   output logic              o_dbus_cyc,
   input  rv_isa_pkg::word_t i_dbus_rdt,
   input  logic              i_dbus_ack
);

   decode_if dec ();

   core_cfg_pkg::bit_cnt_t cnt;
   logic exec_en;
   logic load_en;
   logic pc_update;
   logic cmp_eq;
   logic rs1_bit;
   logic rs2_bit;
   logic alu_rd_bit;
   logic load_bit;
   logic rf_wen;
   logic rf_wbit;

   // Loads write rd in write-back, all others during execution
   assign rf_wen  = dec.rd_write & (load_en | (exec_en & ~dec.is_load));
   assign rf_wbit = load_en ? load_bit : alu_rd_bit;

   insn_decoder decoder (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_insn     (i_ibus_rdt),
      .i_insn_ack (i_ibus_ack),
      .i_exec_en  (exec_en),
      .dec        (dec)
   );

   core_sequencer sequencer (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_dbus_ack  (i_dbus_ack),
      .i_cmp_eq    (cmp_eq),
      .dec         (dec),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_dbus_cyc  (o_dbus_cyc),
      .o_dbus_we   (o_dbus_we),
      .o_exec_en   (exec_en),
      .o_load_en   (load_en),
      .o_cnt       (cnt),
      .o_pc_update (pc_update)
   );

   serial_datapath datapath (
      .clk         (clk),
      .i_rst       (i_rst),
      .dec         (dec),
      .i_exec_en   (exec_en),
      .i_cnt       (cnt),
      .i_pc_update (pc_update),
      .i_rs1_bit   (rs1_bit),
      .i_rs2_bit   (rs2_bit),
      .o_rd_bit    (alu_rd_bit),
      .o_pc        (o_ibus_adr),
      .o_mem_adr   (o_dbus_adr),
      .o_cmp_eq    (cmp_eq)
   );

   serial_regfile regfile (
      .clk       (clk),
      .i_cnt     (cnt),
      .i_rs1     (dec.rs1),
      .i_rs2     (dec.rs2),
      .i_rd      (dec.rd),
      .i_wen     (rf_wen),
      .i_wbit    (rf_wbit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   load_store_unit lsu (
      .clk        (clk),
      .i_exec_en  (exec_en),
      .i_load_en  (load_en),
      .i_store    (dec.is_store),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus_dat (o_dbus_dat),
      .o_load_bit (load_bit)
   );

endmodule

// ==== tb/bus_checker.sv ====
`timescale 1ns/10ps

module bus_checker #(
   parameter int ROWS = 64
) (
   input  logic              clk,
   input  logic              i_rst,
   input  rv_isa_pkg::word_t i_ibus_adr,
   input  logic              i_ibus_cyc,
   input  logic              i_ibus_ack,
   input  rv_isa_pkg::word_t i_dbus_adr,
   input  rv_isa_pkg::word_t i_dbus_dat,
   input  logic              i_dbus_we,
   input  logic              i_dbus_cyc,
   input  logic              i_dbus_ack,
   input  logic [1:0]        i_kind [ROWS],
   input  rv_isa_pkg::word_t i_exp_adr [ROWS],
   input  rv_isa_pkg::word_t i_exp_dat [ROWS],
   input  logic [127:0]      i_name [ROWS],
   output int                o_tests,
   output int                o_errors
);

   localparam logic [1:0] KIND_STORE = 2'd1;
   localparam logic [1:0] KIND_FETCH = 2'd2;

   int   tests = 0;
   int   errors = 0;
   int   cur_row = -1;
   int   pend_row = 0;
   logic rst_q = 1'b0;
   logic fetched = 1'b0;
   logic reset_bad = 1'b0;
   logic fetch_pending = 1'b0;

   assign o_tests  = tests;
   assign o_errors = errors;

   task automatic pass_line(input logic [127:0] name);
      tests = tests + 1;
      $display("ok       %s", name);
   endtask

   task automatic value_error(input logic [127:0] name, input string what,
                              input rv_isa_pkg::word_t exp, input rv_isa_pkg::word_t act);
      tests  = tests + 1;
      errors = errors + 1;
      $display("** Error %s %s: expected %h, actual %h", name, what, exp, act);
   endtask

   task automatic check_fetch();
      int row;
      if (!fetched) begin
         fetched = 1'b1;
         if (reset_bad) begin
            tests  = tests + 1;
            errors = errors + 1;
            $display("Failure in reset_fetch: a bus cycle was active too early");
         end else if (i_ibus_adr != 32'h0) begin
            value_error("reset_fetch", "fetch address", 32'h0, i_ibus_adr);
         end else begin
            pass_line("reset_fetch");
         end
      end else if (fetch_pending) begin
         fetch_pending = 1'b0;
         if (i_ibus_adr != i_exp_adr[pend_row]) begin
            value_error(i_name[pend_row], "next fetch", i_exp_adr[pend_row], i_ibus_adr);
         end else begin
            pass_line(i_name[pend_row]);
         end
      end
      row = int'(i_ibus_adr >> 2);
      cur_row = (i_ibus_adr[1:0] == 2'b00 && row < ROWS) ? row : -1;
      if (cur_row >= 0 && i_kind[cur_row] == KIND_FETCH) begin
         fetch_pending = 1'b1;
         pend_row      = cur_row;
      end
   endtask

   task automatic check_store();
      if (cur_row < 0 || i_kind[cur_row] != KIND_STORE) begin
         errors = errors + 1;
         $display("Failure: unexpected store of %h to address %h", i_dbus_dat, i_dbus_adr);
      end else if (i_dbus_adr != i_exp_adr[cur_row]) begin
         value_error(i_name[cur_row], "store address", i_exp_adr[cur_row], i_dbus_adr);
      end else if (i_dbus_dat != i_exp_dat[cur_row]) begin
         value_error(i_name[cur_row], "store data", i_exp_dat[cur_row], i_dbus_dat);
      end else begin
         pass_line(i_name[cur_row]);
      end
   endtask

   // Sampled on the rising edge, inputs change on the falling one
   always @(posedge clk) begin
      if ((i_rst || rst_q) && (i_ibus_cyc || i_dbus_cyc)) begin
         reset_bad = 1'b1;
      end
      if (!fetched && i_dbus_cyc) begin
         reset_bad = 1'b1;
      end
      rst_q = i_rst;
      if (!i_rst && i_ibus_cyc && i_ibus_ack) begin
         check_fetch();
      end
      if (!i_rst && i_dbus_cyc && i_dbus_ack && i_dbus_we) begin
         check_store();
      end
   end

endmodule

// ==== tb/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;

   localparam int MAX_ROWS   = 64;
   localparam int MAX_DELAY  = 3;
   localparam int RST_CYCLES = 4;
   localparam logic [1:0] KIND_NONE  = 2'd0;
   localparam logic [1:0] KIND_STORE = 2'd1;
   localparam logic [1:0] KIND_FETCH = 2'd2;

   logic              clk;
   logic              i_rst;
   rv_isa_pkg::word_t o_ibus_adr;
   logic              o_ibus_cyc;
   rv_isa_pkg::word_t i_ibus_rdt;
   logic              i_ibus_ack;
   rv_isa_pkg::word_t o_dbus_adr;
   rv_isa_pkg::word_t o_dbus_dat;
   logic              o_dbus_we;
   logic              o_dbus_cyc;
   rv_isa_pkg::word_t i_dbus_rdt;
   logic              i_dbus_ack;

   // Program table, one row per word of instruction memory
   rv_isa_pkg::word_t prog_insn [MAX_ROWS];
   logic [1:0]        prog_kind [MAX_ROWS];
   rv_isa_pkg::word_t exp_adr [MAX_ROWS];
   rv_isa_pkg::word_t exp_dat [MAX_ROWS];
   logic [127:0]      prog_name [MAX_ROWS];

   int   n_rows;
   int   n_tests;
   int   tests_done;
   int   errors;
   int   ibus_wait;
   int   dbus_wait;
   logic table_ready;

   bit_serial_core uut (
      .clk        (clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack)
   );

   bus_checker #(.ROWS(MAX_ROWS)) bus_chk (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_adr (o_ibus_adr),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_adr (o_dbus_adr),
      .i_dbus_dat (o_dbus_dat),
      .i_dbus_we  (o_dbus_we),
      .i_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack),
      .i_kind     (prog_kind),
      .i_exp_adr  (exp_adr),
      .i_exp_dat  (exp_dat),
      .i_name     (prog_name),
      .o_tests    (tests_done),
      .o_errors   (errors)
   );

   function automatic rv_isa_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
   endfunction

   function automatic rv_isa_pkg::word_t enc_i(input rv_isa_pkg::word_t imm,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd,
                                               input rv_isa_pkg::opcode_t op);
      return {imm[11:0], rs1, f3, rd, op};
   endfunction

   function automatic rv_isa_pkg::word_t enc_s(input rv_isa_pkg::word_t imm,
                                               input logic [4:0] rs2, input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};
   endfunction

   function automatic rv_isa_pkg::word_t enc_b(input rv_isa_pkg::word_t imm,
                                               input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
   endfunction

   function automatic rv_isa_pkg::word_t enc_u(input rv_isa_pkg::word_t imm,
                                               input logic [4:0] rd);
      return {imm[31:12], rd, rv_isa_pkg::OP_LUI};
   endfunction

   function automatic rv_isa_pkg::word_t enc_j(input rv_isa_pkg::word_t imm,
                                               input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
   endfunction

   // Load data pattern of the data memory
   function automatic rv_isa_pkg::word_t fill_word(input rv_isa_pkg::word_t adr);
      return (adr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
   endfunction

   function automatic rv_isa_pkg::word_t next_pc();
      return rv_isa_pkg::word_t'(n_rows * 4);
   endfunction

   function automatic rv_isa_pkg::word_t fetch_word(input rv_isa_pkg::word_t adr);
      if ((adr >> 2) < MAX_ROWS) begin
         return prog_insn[adr[7:2]];
      end
      return enc_j(32'h0, 5'd0);
   endfunction

   task automatic add_row(input rv_isa_pkg::word_t insn, input logic [1:0] kind,
                          input logic [127:0] name, input rv_isa_pkg::word_t adr,
                          input rv_isa_pkg::word_t dat);
      prog_insn[n_rows] = insn;
      prog_kind[n_rows] = kind;
      prog_name[n_rows] = name;
      exp_adr[n_rows]   = adr;
      exp_dat[n_rows]   = dat;
      n_rows = n_rows + 1;
   endtask

   // Store with x0 as base, so the address is the offset
   task automatic sw_row(input logic [4:0] rs2, input rv_isa_pkg::word_t off,
                         input logic [127:0] name, input rv_isa_pkg::word_t dat);
      add_row(enc_s(off, rs2, 5'd0), KIND_STORE, name, off, dat);
   endtask

   // Stands where control flow must not go; a store here is unexpected
   task automatic skipped_row();
      add_row(enc_s(32'h1F0, 5'd1, 5'd0), KIND_NONE, "skipped", '0, '0);
   endtask

   task automatic build_program();
      rv_isa_pkg::word_t a;
      rv_isa_pkg::word_t b;
      rv_isa_pkg::word_t p;
      a = 32'd291;
      b = 32'd0 - 32'd677;
      n_rows = 0;
      for (int i = 0; i < MAX_ROWS; i++) begin
         prog_insn[i] = enc_j(32'h0, 5'd0);
         prog_kind[i] = KIND_NONE;
         prog_name[i] = "idle";
         exp_adr[i]   = '0;
         exp_dat[i]   = '0;
      end
      add_row(enc_i(a, 5'd0, 3'b000, 5'd1, rv_isa_pkg::OP_IMM), KIND_NONE, "li_x1", '0, '0);
      add_row(enc_i(b, 5'd0, 3'b000, 5'd2, rv_isa_pkg::OP_IMM), KIND_NONE, "li_x2", '0, '0);
      add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), KIND_NONE, "add_op", '0, '0);
      sw_row(5'd3, 32'h100, "add", a + b);
      add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), KIND_NONE, "sub_op", '0, '0);
      sw_row(5'd3, 32'h104, "sub", a - b);
      add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), KIND_NONE, "and_op", '0, '0);
      sw_row(5'd3, 32'h108, "and", a & b);
      add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), KIND_NONE, "or_op", '0, '0);
      sw_row(5'd3, 32'h10C, "or", a | b);
      add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), KIND_NONE, "xor_op", '0, '0);
      sw_row(5'd3, 32'h110, "xor", a ^ b);
      add_row(enc_i(-32'd5, 5'd1, 3'b000, 5'd4, rv_isa_pkg::OP_IMM), KIND_NONE, "", '0, '0);
      sw_row(5'd4, 32'h114, "addi", a - 32'd5);
      add_row(enc_i(32'h7F0, 5'd2, 3'b111, 5'd4, rv_isa_pkg::OP_IMM), KIND_NONE, "", '0, '0);
      sw_row(5'd4, 32'h118, "andi", b & 32'h7F0);
      add_row(enc_i(-32'd16, 5'd1, 3'b110, 5'd4, rv_isa_pkg::OP_IMM), KIND_NONE, "", '0, '0);
      sw_row(5'd4, 32'h11C, "ori", a | 32'hFFFF_FFF0);
      add_row(enc_i(32'h555, 5'd2, 3'b100, 5'd4, rv_isa_pkg::OP_IMM), KIND_NONE, "", '0, '0);
      sw_row(5'd4, 32'h120, "xori", b ^ 32'h555);
      add_row(enc_u(32'hABCD_E000, 5'd5), KIND_NONE, "lui_op", '0, '0);
      sw_row(5'd5, 32'h124, "lui", 32'hABCD_E000);
      add_row(enc_s(32'h10, 5'd1, 5'd5), KIND_STORE, "sw_base", 32'hABCD_E010, a);
      p = next_pc();
      add_row(enc_j(32'd12, 5'd6), KIND_FETCH, "jal", p + 32'd12, '0);
      skipped_row();
      skipped_row();
      sw_row(5'd6, 32'h128, "jal_link", p + 32'd4);
      add_row(enc_b(32'd8, 5'd1, 5'd1, 3'b000), KIND_FETCH, "beq_taken", next_pc() + 8, '0);
      skipped_row();
      add_row(enc_b(32'd8, 5'd2, 5'd1, 3'b000), KIND_FETCH, "beq_not", next_pc() + 4, '0);
      add_row(enc_b(32'd8, 5'd2, 5'd1, 3'b001), KIND_FETCH, "bne_taken", next_pc() + 8, '0);
      skipped_row();
      add_row(enc_b(32'd8, 5'd1, 5'd1, 3'b001), KIND_FETCH, "bne_not", next_pc() + 4, '0);
      add_row(enc_i(32'h40, 5'd0, 3'b010, 5'd8, rv_isa_pkg::OP_LOAD), KIND_NONE, "", '0, '0);
      sw_row(5'd8, 32'h12C, "lw_sw", fill_word(32'h40));
      add_row(enc_i(32'h44, 5'd0, 3'b010, 5'd0, rv_isa_pkg::OP_LOAD), KIND_NONE, "", '0, '0);
      add_row(enc_i(32'd5, 5'd0, 3'b000, 5'd0, rv_isa_pkg::OP_IMM), KIND_NONE, "", '0, '0);
      sw_row(5'd0, 32'h130, "x0_zero", '0);
      // Park on a jump to itself
      add_row(enc_j(32'h0, 5'd0), KIND_NONE, "park", '0, '0);
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // Instruction bus, random ack delay
   always @(negedge clk) begin
      i_ibus_ack <= 1'b0;
      if (o_ibus_cyc && !i_ibus_ack) begin
         if (ibus_wait == 0) begin
            i_ibus_ack <= 1'b1;
            i_ibus_rdt <= fetch_word(o_ibus_adr);
            ibus_wait  <= int'($urandom % (MAX_DELAY + 1));
         end else begin
            ibus_wait <= ibus_wait - 1;
         end
      end
   end

   // Data bus, loads answered from the fill pattern
   always @(negedge clk) begin
      i_dbus_ack <= 1'b0;
      if (o_dbus_cyc && !i_dbus_ack) begin
         if (dbus_wait == 0) begin
            i_dbus_ack <= 1'b1;
            i_dbus_rdt <= fill_word(o_dbus_adr);
            dbus_wait  <= int'($urandom % (MAX_DELAY + 1));
         end else begin
            dbus_wait <= dbus_wait - 1;
         end
      end
   end

   initial begin
      void'($urandom(32'h7c64));
      i_rst       = 1'b1;
      i_ibus_ack  = 1'b0;
      i_ibus_rdt  = '0;
      i_dbus_ack  = 1'b0;
      i_dbus_rdt  = '0;
      table_ready = 1'b0;
      build_program();
      n_tests = 1;
      for (int i = 0; i < n_rows; i++) begin
         if (prog_kind[i] != KIND_NONE) begin
            n_tests = n_tests + 1;
         end
      end
      ibus_wait   = int'($urandom % (MAX_DELAY + 1));
      dbus_wait   = int'($urandom % (MAX_DELAY + 1));
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      i_rst = 1'b0;
      wait (tests_done == n_tests);
      repeat (2) @(posedge clk);
      $display("Tests run: %0d, errors: %0d", tests_done, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Watchdog sized from the program length and the worst ack delay
   initial begin
      wait (table_ready);
      repeat (RST_CYCLES + n_rows * (36 + 3 * MAX_DELAY + 40)) @(posedge clk);
      $display("Timeout: only %0d of %0d tests finished in time", tests_done, n_tests);
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== compile.f ====
verilog/rv_isa_pkg.sv
verilog/core_cfg_pkg.sv
verilog/decode_if.sv
verilog/insn_decoder.sv
verilog/core_sequencer.sv
verilog/serial_datapath.sv
verilog/serial_regfile.sv
verilog/load_store_unit.sv
verilog/bit_serial_core.sv
tb/bus_checker.sv
tb/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
   -f compile.f -o core_tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "Build failed, see $BUILD_LOG"
   exit 1
fi

./obj_dir/core_tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Regression passed$" "$SIM_LOG"; then
   exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
